// File: src.f
+incdir+testbench
source/rs_cfg_pkg.sv
source/rs_types_pkg.sv
source/rs_pick.sv
source/rs_dispatch.sv
source/rs_wakeup.sv
source/rs_issue.sv
source/rs_entry_array.sv
source/rs_top.sv
testbench/rs_tb.sv

// File: Makefile
# Verilator build and run for the reservation station testbench

VERILATOR ?= verilator
TOP       ?= rs_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation FAILED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass or fail comes from the log, the simulator status is kept as well
run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/rs_ref_model.svh
// Reference model of the reservation station
// Expected credit and issue channels per cycle, entry state stepped per edge
`ifndef RS_REF_MODEL_SVH
`define RS_REF_MODEL_SVH

// Model state, one valid bit and one instruction per entry
logic [ENTRY_NUM-1:0] model_valid = '0;
rs_inst_t             model_entry [ENTRY_NUM];

// ----------------------------------------
// Expected outputs for the current cycle
// ----------------------------------------
function automatic void predict_outputs(
    input  fu_class_t              rdy,
    output rs_issue_t [IS_NUM-1:0] exp_is,
    output logic [ENTRY_NUM-1:0]   exp_clr,
    output logic [DP_CNT_W-1:0]    exp_avail
);
    int ch;
    int free;
    exp_is  = '0;
    exp_clr = '0;
    ch      = 0;
    free    = 0;
    for (int e = 0; e < ENTRY_NUM; e++) begin
        // Both operands ready and the unit class open, lowest entry first
        if (ch < IS_NUM && model_valid[e]
            && model_entry[e].tag1_ready && model_entry[e].tag2_ready
            && (model_entry[e].fu_class & rdy) != '0) begin
            exp_is[ch].valid = 1'b1;
            exp_is[ch].inst  = model_entry[e];
            exp_clr[e]       = 1'b1;
            ch++;
        end
        // Issuing entries count as free for the next edge
        if (!model_valid[e] || exp_clr[e]) begin
            free++;
        end
    end
    exp_avail = DP_CNT_W'((free > DP_NUM) ? DP_NUM : free);
endfunction

// ----------------------------------------
// State update at a clock edge
// ----------------------------------------
task automatic model_step(
    input logic                   rst,
    input logic                   flush,
    input logic [DP_CNT_W-1:0]    num,
    input rs_inst_t [DP_NUM-1:0]  insts,
    input cdb_t [CDB_NUM-1:0]     cdb,
    input logic [ENTRY_NUM-1:0]   clr
);
    int k;
    if (rst || flush) begin
        model_valid = '0;
    end else begin
        // Wakeup on waiting entries only, issue wins over it
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (model_valid[e] && !clr[e] && cdb[c].valid) begin
                    if (cdb[c].tag == model_entry[e].tag1) begin
                        model_entry[e].tag1_ready = 1'b1;
                    end
                    if (cdb[c].tag == model_entry[e].tag2) begin
                        model_entry[e].tag2_ready = 1'b1;
                    end
                end
            end
        end
        model_valid = model_valid & ~clr;
        // Slot k lands in the k-th free entry
        k = 0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (!model_valid[e] && k < int'(num)) begin
                model_entry[e] = insts[k];
                model_valid[e] = 1'b1;
                k++;
            end
        end
    end
endtask

`endif

// File: testbench/rs_tb.sv
// Reservation station testbench
// Directed and random stimulus, checked every cycle against a reference model
`timescale 1ns/1ps
`default_nettype none

module rs_tb
    import rs_cfg_pkg::*, rs_types_pkg::*;
();

    localparam int ENTRY_NUM   = RS_ENTRY_NUM;
    localparam int DP_NUM      = RS_DP_NUM;
    localparam int IS_NUM      = RS_IS_NUM;
    localparam int CDB_NUM     = RS_CDB_NUM;
    localparam int DP_CNT_W    = $clog2(DP_NUM + 1);
    localparam int RAND_CYCLES = 2000;
    // Cycles allowed for an expected issue
    localparam int WAIT_LIMIT  = 8;

    // One-hot unit classes, alu is the top bit
    localparam fu_class_t FU_ALU    = 5'b10000;
    localparam fu_class_t FU_MULT   = 5'b01000;
    localparam fu_class_t FU_BRANCH = 5'b00100;
    localparam fu_class_t FU_ALL    = 5'b11111;

    logic                   clk_i;
    logic                   rst_i;
    logic                   flush_i;
    rs_inst_t [DP_NUM-1:0]  dp_inst_i;
    logic [DP_CNT_W-1:0]    dp_num_i;
    logic [DP_CNT_W-1:0]    avail_num_o;
    cdb_t [CDB_NUM-1:0]     cdb_i;
    fu_class_t              fu_ready_i;
    rs_issue_t [IS_NUM-1:0] is_o;

    int     error_count = 0;
    int     check_count = 0;
    string  test_name   = "reset";
    integer seed        = 32'he4ad;

    `include "rs_ref_model.svh"

    rs_top #(
        .ENTRY_NUM   (ENTRY_NUM),
        .DP_NUM      (DP_NUM),
        .IS_NUM      (IS_NUM),
        .CDB_NUM     (CDB_NUM)
    ) dut0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .dp_inst_i   (dp_inst_i),
        .dp_num_i    (dp_num_i),
        .avail_num_o (avail_num_o),
        .cdb_i       (cdb_i),
        .fu_ready_i  (fu_ready_i),
        .is_o        (is_o)
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return r % n;
    endfunction

    // Payload fields follow from the tags so a mixup shows up
    function automatic rs_inst_t build_inst(input tag_t dest, input tag_t src1,
                                            input logic rdy1, input tag_t src2,
                                            input logic rdy2, input fu_class_t cls);
        rs_inst_t ins;
        ins.pc         = 32'h0000_4000 + {24'd0, dest, 2'b00};
        ins.inst       = {src1, src2, dest, 14'h1357};
        ins.tag        = dest;
        ins.tag1       = src1;
        ins.tag2       = src2;
        ins.tag1_ready = rdy1;
        ins.tag2_ready = rdy2;
        ins.rob_idx    = dest[RS_ROB_W-1:0];
        ins.fu_class   = cls;
        return ins;
    endfunction

    task automatic idle_inputs();
        flush_i  = 1'b0;
        dp_num_i = '0;
        cdb_i    = '0;
    endtask

    // One cycle of the current inputs, then back to idle
    task automatic next_cycle();
        @(negedge clk_i);
        idle_inputs();
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            error_count++;
            $display("ERROR %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_channel(input int k, input rs_inst_t expected);
        check_count++;
        assert (is_o[k].valid && is_o[k].inst == expected) else begin
            error_count++;
            $display("ERROR %s channel %0d expected %h actual valid=%0b %h",
                     test_name, k, expected, is_o[k].valid, is_o[k].inst);
        end
    endtask

    // Bounded wait for a destination tag on any channel
    task automatic wait_issue(input tag_t dest, input int limit);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk_i);
            for (int k = 0; k < IS_NUM; k++) begin
                if (is_o[k].valid && is_o[k].inst.tag == dest) begin
                    seen = 1'b1;
                end
            end
            n++;
        end
        check_count++;
        assert (seen) else begin
            error_count++;
            $display("ERROR %s timed out after %0d cycles waiting for tag %0d to issue",
                     test_name, limit, dest);
        end
        @(negedge clk_i);
        idle_inputs();
    endtask

    task automatic random_inputs();
        rs_issue_t [IS_NUM-1:0] pred_is;
        logic [ENTRY_NUM-1:0]   pred_clr;
        logic [DP_CNT_W-1:0]    pred_avail;
        fu_ready_i = 5'(rand_below(32));
        flush_i    = (rand_below(64) == 0);
        // Credit from the model, never more than the station can take
        predict_outputs(fu_ready_i, pred_is, pred_clr, pred_avail);
        dp_num_i = DP_CNT_W'(rand_below(int'(pred_avail) + 1));
        for (int k = 0; k < DP_NUM; k++) begin
            dp_inst_i[k] = build_inst(tag_t'(rand_below(64)), tag_t'(rand_below(16)),
                                      rand_below(2) == 1, tag_t'(rand_below(16)),
                                      rand_below(2) == 1,
                                      fu_class_t'(5'b00001 << rand_below(5)));
            dp_inst_i[k].pc = pc_t'($random(seed));
        end
        for (int c = 0; c < CDB_NUM; c++) begin
            cdb_i[c].valid = (rand_below(2) == 1);
            cdb_i[c].tag   = tag_t'(rand_below(16));
            // No broadcast meets a consumer in its dispatch cycle
            for (int k = 0; k < DP_NUM; k++) begin
                if (k < int'(dp_num_i) && (cdb_i[c].tag == dp_inst_i[k].tag1
                                           || cdb_i[c].tag == dp_inst_i[k].tag2)) begin
                    cdb_i[c].valid = 1'b0;
                end
            end
        end
    endtask

    // ----------------------------------------
    // Cycle compare against the model
    // ----------------------------------------
    always @(posedge clk_i) begin : compare_outputs
        rs_issue_t [IS_NUM-1:0] exp_is;
        logic [ENTRY_NUM-1:0]   exp_clr;
        logic [DP_CNT_W-1:0]    exp_avail;
        predict_outputs(fu_ready_i, exp_is, exp_clr, exp_avail);
        if (!rst_i) begin
            check_count++;
            assert (avail_num_o == exp_avail) else begin
                error_count++;
                $display("ERROR %s avail_num expected %0d actual %0d",
                         test_name, exp_avail, avail_num_o);
            end
            for (int k = 0; k < IS_NUM; k++) begin
                check_count++;
                assert (is_o[k] == exp_is[k]) else begin
                    error_count++;
                    $display("ERROR %s is_o[%0d] expected %h actual %h",
                             test_name, k, exp_is[k], is_o[k]);
                end
            end
        end
        model_step(rst_i, flush_i, dp_num_i, dp_inst_i, cdb_i, exp_clr);
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        rs_inst_t ins_a;
        rs_inst_t ins_b;
        rst_i      = 1'b1;
        dp_inst_i  = '0;
        fu_ready_i = FU_ALL;
        idle_inputs();
        // Two rising edges under reset
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Two ready instructions, channels in entry order
        test_name    = "ready issue";
        ins_a        = build_inst(6'd1, 6'd50, 1'b1, 6'd51, 1'b1, FU_ALU);
        ins_b        = build_inst(6'd2, 6'd52, 1'b1, 6'd53, 1'b1, FU_ALU);
        dp_inst_i[0] = ins_a;
        dp_inst_i[1] = ins_b;
        dp_num_i     = DP_CNT_W'(2);
        next_cycle();
        @(posedge clk_i);
        check_channel(0, ins_a);
        check_channel(1, ins_b);
        @(negedge clk_i);

        // Waits on tag1, an unrelated tag does not release it
        test_name    = "wakeup";
        dp_inst_i[0] = build_inst(6'd10, 6'd20, 1'b0, 6'd21, 1'b1, FU_ALU);
        dp_num_i     = DP_CNT_W'(1);
        next_cycle();
        repeat (3) next_cycle();
        cdb_i[0].valid = 1'b1;
        cdb_i[0].tag   = 6'd22;
        next_cycle();
        next_cycle();
        cdb_i[0].valid = 1'b1;
        cdb_i[0].tag   = 6'd20;
        next_cycle();
        wait_issue(6'd10, WAIT_LIMIT);

        // Mult held back while alu behind it goes
        test_name       = "unit stall";
        fu_ready_i      = FU_ALL;
        fu_ready_i.mult = 1'b0;
        ins_a           = build_inst(6'd30, 6'd0, 1'b1, 6'd0, 1'b1, FU_MULT);
        ins_b           = build_inst(6'd31, 6'd0, 1'b1, 6'd0, 1'b1, FU_ALU);
        dp_inst_i[0]    = ins_a;
        dp_inst_i[1]    = ins_b;
        dp_num_i        = DP_CNT_W'(2);
        next_cycle();
        @(posedge clk_i);
        check_channel(0, ins_b);
        check_value("channel 1 valid", 0, int'(is_o[1].valid));
        @(negedge clk_i);
        repeat (3) next_cycle();
        fu_ready_i.mult = 1'b1;
        wait_issue(6'd30, WAIT_LIMIT);

        // Fill every entry with all units stalled
        test_name  = "credit";
        fu_ready_i = '0;
        for (int n = 0; n < ENTRY_NUM / DP_NUM; n++) begin
            for (int k = 0; k < DP_NUM; k++) begin
                dp_inst_i[k] = build_inst(tag_t'(40 + n * DP_NUM + k), 6'd0, 1'b1,
                                          6'd0, 1'b1,
                                          (n == 0 && k == 0) ? FU_BRANCH : FU_ALU);
            end
            dp_num_i = DP_CNT_W'(DP_NUM);
            next_cycle();
        end
        @(posedge clk_i);
        check_value("credit when full", 0, int'(avail_num_o));
        @(negedge clk_i);
        // Only the branch entry can leave
        fu_ready_i.branch = 1'b1;
        @(posedge clk_i);
        check_value("credit with one issue", 1, int'(avail_num_o));
        @(negedge clk_i);
        fu_ready_i = '0;

        // Flush with units open, nothing left afterwards
        test_name  = "flush";
        fu_ready_i = FU_ALL;
        flush_i    = 1'b1;
        next_cycle();
        @(posedge clk_i);
        for (int k = 0; k < IS_NUM; k++) begin
            check_value("valid after flush", 0, int'(is_o[k].valid));
        end
        check_value("credit after flush", DP_NUM, int'(avail_num_o));
        @(negedge clk_i);

        // Random traffic, model does the checking
        test_name = "random";
        for (int n = 0; n < RAND_CYCLES; n++) begin
            random_inputs();
            @(negedge clk_i);
        end
        idle_inputs();
        repeat (4) @(negedge clk_i);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rs_top.sv
// Reservation station top level
// Single-thread station with credit dispatch, CDB wakeup and multi-issue
`timescale 1ns/1ps
`default_nettype none

module rs_top
    import rs_cfg_pkg::*, rs_types_pkg::*;
#(
    parameter int  ENTRY_NUM = RS_ENTRY_NUM,
    parameter int  DP_NUM    = RS_DP_NUM,
    parameter int  IS_NUM    = RS_IS_NUM,
    parameter int  CDB_NUM   = RS_CDB_NUM,
    localparam int DP_CNT_W  = $clog2(DP_NUM+1)
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    // Dispatch, credit based
    input  rs_inst_t [DP_NUM-1:0]  dp_inst_i,
    input  logic [DP_CNT_W-1:0]    dp_num_i,
    output logic [DP_CNT_W-1:0]    avail_num_o,
    // Broadcast
    input  cdb_t [CDB_NUM-1:0]     cdb_i,
    // Issue
    input  fu_class_t              fu_ready_i,
    output rs_issue_t [IS_NUM-1:0] is_o
);

    rs_inst_t [ENTRY_NUM-1:0] entries;
    logic [ENTRY_NUM-1:0]     valid;
    logic [ENTRY_NUM-1:0]     wake1;
    logic [ENTRY_NUM-1:0]     wake2;
    logic [ENTRY_NUM-1:0]     issue_ok;
    logic [ENTRY_NUM-1:0]     is_clr;
    logic [ENTRY_NUM-1:0]     dp_we;
    rs_inst_t [ENTRY_NUM-1:0] dp_data;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    rs_entry_array #(
        .ENTRY_NUM (ENTRY_NUM)
    ) u_entry_array (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush_i),
        .dp_we_i   (dp_we),
        .dp_data_i (dp_data),
        .wake1_i   (wake1),
        .wake2_i   (wake2),
        .is_clr_i  (is_clr),
        .entries_o (entries),
        .valid_o   (valid)
    );

    // ----------------------------------------
    // Combinational paths
    // ----------------------------------------
    rs_dispatch #(
        .ENTRY_NUM   (ENTRY_NUM),
        .DP_NUM      (DP_NUM)
    ) u_dispatch (
        .valid_i     (valid),
        .is_clr_i    (is_clr),
        .dp_inst_i   (dp_inst_i),
        .dp_num_i    (dp_num_i),
        .dp_we_o     (dp_we),
        .dp_data_o   (dp_data),
        .avail_num_o (avail_num_o)
    );

    rs_wakeup #(
        .ENTRY_NUM  (ENTRY_NUM),
        .CDB_NUM    (CDB_NUM)
    ) u_wakeup (
        .entries_i  (entries),
        .valid_i    (valid),
        .cdb_i      (cdb_i),
        .fu_ready_i (fu_ready_i),
        .wake1_o    (wake1),
        .wake2_o    (wake2),
        .issue_ok_o (issue_ok)
    );

    rs_issue #(
        .ENTRY_NUM  (ENTRY_NUM),
        .IS_NUM     (IS_NUM)
    ) u_issue (
        .issue_ok_i (issue_ok),
        .entries_i  (entries),
        .is_o       (is_o),
        .is_clr_o   (is_clr)
    );

endmodule

`default_nettype wire

// File: source/rs_entry_array.sv
// Reservation station entry storage
// Valid bit and instruction per entry, updated once per clock edge
`timescale 1ns/1ps
`default_nettype none

module rs_entry_array
    import rs_cfg_pkg::*, rs_types_pkg::*;
#(
    parameter int ENTRY_NUM = RS_ENTRY_NUM
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     flush_i,
    input  logic [ENTRY_NUM-1:0]     dp_we_i,
    input  rs_inst_t [ENTRY_NUM-1:0] dp_data_i,
    input  logic [ENTRY_NUM-1:0]     wake1_i,
    input  logic [ENTRY_NUM-1:0]     wake2_i,
    input  logic [ENTRY_NUM-1:0]     is_clr_i,
    output rs_inst_t [ENTRY_NUM-1:0] entries_o,
    output logic [ENTRY_NUM-1:0]     valid_o
);

    logic [ENTRY_NUM-1:0]     valid_q;
    rs_inst_t [ENTRY_NUM-1:0] entry_q;

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------
    // Reset or flush, then dispatch, then issue clear
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (rst_i || flush_i) begin
                valid_q[e] <= 1'b0;
            end else if (dp_we_i[e]) begin
                valid_q[e] <= 1'b1;
            end else if (is_clr_i[e]) begin
                valid_q[e] <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Payload
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (dp_we_i[e]) begin
                // Broadcast in the dispatch cycle is lost
                entry_q[e] <= dp_data_i[e];
            end else if (!is_clr_i[e]) begin
                // Issue beats wakeup on the same entry
                if (wake1_i[e]) begin
                    entry_q[e].tag1_ready <= 1'b1;
                end
                if (wake2_i[e]) begin
                    entry_q[e].tag2_ready <= 1'b1;
                end
            end
        end
    end

    assign entries_o = entry_q;
    assign valid_o   = valid_q;

endmodule

`default_nettype wire

// File: source/rs_issue.sv
// Reservation station issue select
// Picks ready entries lowest index first and routes them to channels
`timescale 1ns/1ps
`default_nettype none

module rs_issue
    import rs_cfg_pkg::*, rs_types_pkg::*;
#(
    parameter int ENTRY_NUM = RS_ENTRY_NUM,
    parameter int IS_NUM    = RS_IS_NUM
) (
    input  logic [ENTRY_NUM-1:0]     issue_ok_i,
    input  rs_inst_t [ENTRY_NUM-1:0] entries_i,
    output rs_issue_t [IS_NUM-1:0]   is_o,
    output logic [ENTRY_NUM-1:0]     is_clr_o
);

    localparam int IDX_W = $clog2(ENTRY_NUM);

    logic [IS_NUM-1:0][IDX_W-1:0] pick_idx;
    logic [IS_NUM-1:0]            pick_valid;

    // ----------------------------------------
    // Selection
    // ----------------------------------------
    // Fixed priority, lowest entry first
    rs_pick #(
        .IN_W    (ENTRY_NUM),
        .OUT_NUM (IS_NUM)
    ) u_is_pick (
        .bits_i  (issue_ok_i),
        .idx_o   (pick_idx),
        .valid_o (pick_valid)
    );

    // ----------------------------------------
    // Issue switch
    // ----------------------------------------
    // k-th pick drives channel k
    always_comb begin
        is_o     = '0;
        is_clr_o = '0;
        for (int k = 0; k < IS_NUM; k++) begin
            for (int e = 0; e < ENTRY_NUM; e++) begin
                if (pick_valid[k] && (pick_idx[k] == IDX_W'(e))) begin
                    is_o[k].valid = 1'b1;
                    // Source tags travel with the payload
                    is_o[k].inst  = entries_i[e];
                    // Entry leaves at the next edge
                    is_clr_o[e]   = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rs_wakeup.sv
// Reservation station wakeup
// CDB tag comparators and per-entry ready-to-issue check
`timescale 1ns/1ps
`default_nettype none

module rs_wakeup
    import rs_cfg_pkg::*, rs_types_pkg::*;
#(
    parameter int ENTRY_NUM = RS_ENTRY_NUM,
    parameter int CDB_NUM   = RS_CDB_NUM
) (
    input  rs_inst_t [ENTRY_NUM-1:0] entries_i,
    input  logic [ENTRY_NUM-1:0]     valid_i,
    input  cdb_t [CDB_NUM-1:0]       cdb_i,
    input  fu_class_t                fu_ready_i,
    output logic [ENTRY_NUM-1:0]     wake1_o,
    output logic [ENTRY_NUM-1:0]     wake2_o,
    output logic [ENTRY_NUM-1:0]     issue_ok_o
);

    // ----------------------------------------
    // Comparator network
    // ----------------------------------------
    // Every entry against every valid broadcast
    always_comb begin
        wake1_o = '0;
        wake2_o = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (valid_i[e] && cdb_i[c].valid) begin
                    if (cdb_i[c].tag == entries_i[e].tag1) begin
                        wake1_o[e] = 1'b1;
                    end
                    if (cdb_i[c].tag == entries_i[e].tag2) begin
                        wake2_o[e] = 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Ready-to-issue
    // ----------------------------------------
    // Stored ready bits only, so a wakeup counts from the next cycle
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            issue_ok_o[e] = valid_i[e]
                && entries_i[e].tag1_ready
                && entries_i[e].tag2_ready
                // Unit class of this entry must accept work
                && ((entries_i[e].fu_class & fu_ready_i) != '0);
        end
    end

endmodule

`default_nettype wire

// File: source/rs_dispatch.sv
// Reservation station dispatch
// Free entry count, dispatch credit and slot-to-entry routing
`timescale 1ns/1ps
`default_nettype none

module rs_dispatch
    import rs_cfg_pkg::*, rs_types_pkg::*;
#(
    parameter int  ENTRY_NUM = RS_ENTRY_NUM,
    parameter int  DP_NUM    = RS_DP_NUM,
    localparam int DP_CNT_W  = $clog2(DP_NUM+1)
) (
    input  logic [ENTRY_NUM-1:0]     valid_i,
    input  logic [ENTRY_NUM-1:0]     is_clr_i,
    input  rs_inst_t [DP_NUM-1:0]    dp_inst_i,
    input  logic [DP_CNT_W-1:0]      dp_num_i,
    output logic [ENTRY_NUM-1:0]     dp_we_o,
    output rs_inst_t [ENTRY_NUM-1:0] dp_data_o,
    output logic [DP_CNT_W-1:0]      avail_num_o
);

    localparam int IDX_W  = $clog2(ENTRY_NUM);
    localparam int FREE_W = $clog2(ENTRY_NUM+1);

    logic [ENTRY_NUM-1:0]          free_vec;
    logic [FREE_W-1:0]             free_cnt;
    logic [DP_NUM-1:0][IDX_W-1:0]  pick_idx;
    logic [DP_NUM-1:0]             pick_valid;

    // ----------------------------------------
    // Free entries for the next edge
    // ----------------------------------------
    // An entry issuing now can take a new instruction at the same edge
    assign free_vec = ~valid_i | is_clr_i;

    always_comb begin
        free_cnt = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            free_cnt = free_cnt + FREE_W'(free_vec[e]);
        end
        // Credit saturates at the dispatch width
        if (free_cnt >= FREE_W'(DP_NUM)) begin
            avail_num_o = DP_CNT_W'(DP_NUM);
        end else begin
            avail_num_o = DP_CNT_W'(free_cnt);
        end
    end

    // First DP_NUM free entries
    rs_pick #(
        .IN_W    (ENTRY_NUM),
        .OUT_NUM (DP_NUM)
    ) u_dp_pick (
        .bits_i  (free_vec),
        .idx_o   (pick_idx),
        .valid_o (pick_valid)
    );

    // ----------------------------------------
    // Slot k goes to the k-th free entry
    // ----------------------------------------
    always_comb begin
        dp_we_o   = '0;
        dp_data_o = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int k = 0; k < DP_NUM; k++) begin
                // Only slots below dp_num_i carry an instruction
                if (pick_valid[k] && (DP_CNT_W'(k) < dp_num_i)
                    && (pick_idx[k] == IDX_W'(e))) begin
                    dp_we_o[e]   = 1'b1;
                    dp_data_o[e] = dp_inst_i[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rs_pick.sv
// Multi-output priority encoder
// Finds the first OUT_NUM set bits, lowest index first
`timescale 1ns/1ps
`default_nettype none

module rs_pick #(
    parameter int  IN_W    = 8,
    parameter int  OUT_NUM = 2,
    localparam int IDX_W   = $clog2(IN_W)
) (
    input  logic [IN_W-1:0]               bits_i,
    output logic [OUT_NUM-1:0][IDX_W-1:0] idx_o,
    output logic [OUT_NUM-1:0]            valid_o
);

    // Bits not yet claimed by an earlier output
    logic [IN_W-1:0] remain;
    // Current output has found its bit
    logic            found;

    always_comb begin
        remain  = bits_i;
        idx_o   = '0;
        valid_o = '0;
        found   = 1'b0;
        for (int k = 0; k < OUT_NUM; k++) begin
            found = 1'b0;
            // Lowest remaining bit wins
            for (int i = 0; i < IN_W; i++) begin
                if (remain[i] && !found) begin
                    found     = 1'b1;
                    idx_o[k]  = IDX_W'(i);
                    // Hide it from later outputs
                    remain[i] = 1'b0;
                end
            end
            valid_o[k] = found;
        end
    end

endmodule

`default_nettype wire

// File: source/rs_types_pkg.sv
// Reservation station data types
// Instruction, broadcast, unit readiness and issue slot structs
`default_nettype none

package rs_types_pkg;

    import rs_cfg_pkg::*;

    // ----------------------------------------
    // Functional unit classes
    // ----------------------------------------
    // One-hot in an instruction
    // Any combination as unit ready flags
    typedef struct packed {
        logic alu;
        logic mult;
        logic branch;
        logic load;
        logic store;
    } fu_class_t;

    // ----------------------------------------
    // Decoded instruction as held in an entry
    // ----------------------------------------
    typedef struct packed {
        pc_t        pc;
        inst_word_t inst;
        // Destination tag
        tag_t       tag;
        // Source tags and their ready bits
        tag_t       tag1;
        tag_t       tag2;
        logic       tag1_ready;
        logic       tag2_ready;
        rob_idx_t   rob_idx;
        fu_class_t  fu_class;
    } rs_inst_t;

    // Common data bus broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    // One issue channel
    typedef struct packed {
        logic     valid;
        rs_inst_t inst;
    } rs_issue_t;

endpackage

`default_nettype wire

// File: source/rs_cfg_pkg.sv
// Reservation station configuration
// Default sizes and the fixed-width vector types shared by all blocks
`default_nettype none

package rs_cfg_pkg;

    // ----------------------------------------
    // Default sizes
    // ----------------------------------------
    localparam int RS_ENTRY_NUM = 8;
    localparam int RS_DP_NUM    = 2;
    localparam int RS_IS_NUM    = 2;
    localparam int RS_CDB_NUM   = 2;

    // Field widths
    localparam int RS_TAG_W  = 6;
    localparam int RS_PC_W   = 32;
    localparam int RS_INST_W = 32;
    localparam int RS_ROB_W  = 5;

    // Physical register tag
    typedef logic [RS_TAG_W-1:0]  tag_t;
    typedef logic [RS_PC_W-1:0]   pc_t;
    typedef logic [RS_INST_W-1:0] inst_word_t;
    // Reorder buffer slot
    typedef logic [RS_ROB_W-1:0]  rob_idx_t;

endpackage

`default_nettype wire
